//--- run_sim.sh
#!/bin/sh
# Build and run the softmax regression with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module softmax_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vsoftmax_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
exit 1

//--- sim.f
verilog/softmax_pkg.sv
verilog/mx_exp.sv
verilog/exp_split_fifo.sv
verilog/exp_accumulator.sv
verilog/sum_repeat.sv
verilog/mx_div.sv
verilog/mx_cast.sv
verilog/mxint_softmax.sv
tests/softmax_properties.sv
tests/softmax_tb.sv

//--- tests/softmax_properties.sv
`timescale 1ns/10ps
`default_nettype none

module softmax_properties (
  input wire                         clk,
  input wire                         arst_n,
  input wire softmax_pkg::mx_elem_t  data_out,
  input wire                         data_out_valid,
  input wire                         data_out_ready
);

  // No output while reset is applied
  assert property (@(posedge clk) !arst_n |-> !data_out_valid)
    else $error("data_out_valid high during reset");

  // First cycle out of reset is still quiet
  assert property (@(posedge clk) $rose(arst_n) |-> !data_out_valid)
    else $error("data_out_valid high on first cycle after reset");

  // A stalled output beat holds its value
  assert property (@(posedge clk) disable iff (!arst_n)
                   (data_out_valid && !data_out_ready) |=> data_out_valid)
    else $error("data_out_valid dropped while stalled");

  assert property (@(posedge clk) disable iff (!arst_n)
                   (data_out_valid && !data_out_ready) |=> $stable(data_out))
    else $error("data_out changed while stalled");

endmodule

bind mxint_softmax softmax_properties u_props (.*);

`default_nettype wire

//--- tests/softmax_tb.sv
`timescale 1ns/10ps
`default_nettype none

module softmax_tb;

  localparam int cycle_limit = 4000;
  localparam int vd = softmax_pkg::vec_dim;

  logic                  clk;
  logic                  arst_n;
  softmax_pkg::mx_elem_t data_in;
  logic                  data_in_valid;
  logic                  data_in_ready;
  softmax_pkg::mx_elem_t data_out;
  logic                  data_out_valid;
  logic                  data_out_ready;

  softmax_pkg::mx_elem_t pend[$];
  softmax_pkg::mx_elem_t ref_q[$];
  softmax_pkg::mx_elem_t out_q[$];
  softmax_pkg::mx_elem_t in_vec[vd];
  softmax_pkg::mx_elem_t out_vec[vd];
  int seed = 32'h9a33_0a23;
  int cycle = 0;
  int n_sent = 0;
  int checks = 0;
  int errors = 0;
  int ready_mode = 0;

  mxint_softmax u_dut (
    .clk, .arst_n,
    .data_in, .data_in_valid, .data_in_ready,
    .data_out, .data_out_valid, .data_out_ready
  );

  always #10 clk = ~clk;

  function automatic real decode(input softmax_pkg::mx_elem_t e);
    int m;
    int x;
    m = int'(e.man);
    x = int'(e.exp);
    decode = real'(m) * (2.0 ** (x - 2));
  endfunction

  // Transfers and the cycle limit, sampled at the rising edge
  always @(posedge clk) begin
    cycle++;
    if (cycle >= cycle_limit) begin
      $display("Timeout: outputs did not all return within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end else begin
      if (arst_n && data_in_valid && data_in_ready) begin
        void'(pend.pop_front());
        n_sent++;
      end
      if (arst_n && data_out_valid && data_out_ready) begin
        out_q.push_back(data_out);
      end
      if (arst_n && data_out_valid) begin
        checks++;
        assert (n_sent > 0) else begin
          $display("Output became valid before any input was accepted");
          errors++;
        end
      end
    end
  end

  // DUT inputs change on the falling edge only
  always @(negedge clk) begin
    if (pend.size() > 0) begin
      data_in_valid = 1'b1;
      data_in = pend[0];
    end else begin
      data_in_valid = 1'b0;
      data_in = '0;
    end
    case (ready_mode)
      0: data_out_ready = 1'b1;
      1: data_out_ready = 1'($random(seed));
      default: data_out_ready = 1'b0;
    endcase
  end

  // kind 0 all equal, 1 ramp, 2 random
  task automatic add_vector(input int kind);
    softmax_pkg::mx_elem_t e;
    for (int i = 0; i < vd; i++) begin
      e.exp = '0;
      if (kind == 0) begin
        e.man = 4'sd3;
      end else if (kind == 1) begin
        e.man = 4'(2 * i - 8);
      end else begin
        e.man = 4'($random(seed));
      end
      pend.push_back(e);
      ref_q.push_back(e);
    end
  endtask

  task automatic check_vector(input int kind);
    real total;
    real margin;
    total = 0.0;
    margin = (kind == 1) ? 0.0 : 1.0;
    for (int i = 0; i < vd; i++) begin
      in_vec[i] = ref_q.pop_front();
      out_vec[i] = out_q.pop_front();
      total += decode(out_vec[i]);
    end
    checks++;
    assert (total >= 0.75 && total <= 1.25) else begin
      $display("ERROR %0t: vector sum of data_out expected 0.75..1.25 actual %f", $time, total);
      errors++;
    end
    for (int i = 0; i < vd; i++) begin
      if (kind == 0) begin
        checks++;
        assert (out_vec[i] == out_vec[0]) else begin
          $display("ERROR %0t: data_out[%0d] expected %h actual %h",
                   $time, i, out_vec[0], out_vec[i]);
          errors++;
        end
      end
      for (int j = 0; j < vd; j++) begin
        if (decode(in_vec[i]) > decode(in_vec[j]) + margin) begin
          checks++;
          assert (decode(out_vec[i]) >= decode(out_vec[j])) else begin
            $display("ERROR %0t: data_out[%0d] expected >= %f actual %f",
                     $time, i, decode(out_vec[j]), decode(out_vec[i]));
            errors++;
          end
        end
      end
    end
  endtask

  task automatic collect(input string name, input int kind, input int nvec);
    int err0;
    err0 = errors;
    while (out_q.size() < nvec * vd) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);
    checks++;
    assert (out_q.size() == nvec * vd) else begin
      $display("More outputs returned than elements sent in test %s", name);
      errors++;
    end
    for (int v = 0; v < nvec; v++) begin
      check_vector(kind);
    end
    out_q.delete();
    ref_q.delete();
    $display("test %s: %0d vectors, %0d errors", name, nvec, errors - err0);
  endtask

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    data_in = '0;
    data_in_valid = 1'b0;
    data_out_ready = 1'b1;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    repeat (5) @(posedge clk);

    add_vector(0);
    collect("equal", 0, 1);
    add_vector(1);
    collect("ramp", 1, 1);

    ready_mode = 1;
    for (int v = 0; v < 12; v++) begin
      add_vector(2);
    end
    collect("random_backpressure", 2, 12);

    // Long stall fills every stage
    ready_mode = 2;
    for (int v = 0; v < 4; v++) begin
      add_vector(2);
    end
    repeat (40) @(posedge clk);
    checks++;
    assert (!data_in_ready) else begin
      $display("ERROR %0t: data_in_ready expected 0 actual %b", $time, data_in_ready);
      errors++;
    end
    ready_mode = 1;
    collect("stall_release", 2, 4);

    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/exp_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module exp_accumulator (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire softmax_pkg::mx_elem_t  in_data,
  input  wire                         in_valid,
  output logic                        in_ready,
  output softmax_pkg::mx_sum_t        sum_data,
  output logic                        sum_valid,
  input  wire                         sum_ready
);

  softmax_pkg::mx_sum_t               acc;
  softmax_pkg::mx_sum_t               acc_nxt;
  logic [softmax_pkg::acc_w-1:0]      elem_ext;
  logic signed [softmax_pkg::exp_w:0] exp_diff;
  logic [softmax_pkg::cnt_w-1:0]      cnt;
  logic                               take;

  // Sum is held until taken, no new input meanwhile
  assign in_ready = !sum_valid;
  assign take = in_valid && in_ready;
  assign sum_data = acc;

  always_comb begin
    elem_ext = {{softmax_pkg::cnt_w{1'b0}}, in_data.man, {softmax_pkg::sum_guard{1'b0}}};
    exp_diff = {in_data.exp[softmax_pkg::exp_w-1], in_data.exp} -
               {acc.exp[softmax_pkg::exp_w-1], acc.exp};

    if (cnt == '0) begin
      acc_nxt.man = elem_ext;
      acc_nxt.exp = in_data.exp;
    end else if (exp_diff > 0) begin
      // New maximum exponent, shift the running sum down
      acc_nxt.man = (acc.man >> exp_diff) + elem_ext;
      acc_nxt.exp = in_data.exp;
    end else begin
      acc_nxt.man = acc.man + (elem_ext >> -exp_diff);
      acc_nxt.exp = acc.exp;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      sum_valid <= 1'b0;
    end else begin
      if (sum_valid && sum_ready) begin
        sum_valid <= 1'b0;
      end
      if (take) begin
        if (cnt == softmax_pkg::cnt_w'(softmax_pkg::vec_dim - 1)) begin
          cnt <= '0;
          sum_valid <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      acc <= acc_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/exp_split_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module exp_split_fifo (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire softmax_pkg::mx_elem_t  in_data,
  input  wire                         in_valid,
  output logic                        in_ready,
  output softmax_pkg::mx_elem_t       str_data,
  output logic                        str_valid,
  input  wire                         str_ready,
  output softmax_pkg::mx_elem_t       fifo_data,
  output logic                        fifo_valid,
  input  wire                         fifo_ready
);

  softmax_pkg::mx_elem_t          mem [softmax_pkg::fifo_depth];
  logic [softmax_pkg::fifo_aw:0]  wr_ptr;
  logic [softmax_pkg::fifo_aw:0]  rd_ptr;
  logic                           full;
  logic                           empty;
  logic                           push;
  logic                           pop;

  // Pointers carry one wrap bit above the address
  assign full = (wr_ptr[softmax_pkg::fifo_aw] != rd_ptr[softmax_pkg::fifo_aw]) &&
                (wr_ptr[softmax_pkg::fifo_aw-1:0] == rd_ptr[softmax_pkg::fifo_aw-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // Both copies leave together
  assign in_ready = str_ready && !full;
  assign str_valid = in_valid && !full;
  assign str_data = in_data;
  assign push = in_valid && in_ready;

  assign fifo_valid = !empty;
  assign fifo_data = mem[rd_ptr[softmax_pkg::fifo_aw-1:0]];
  assign pop = fifo_valid && fifo_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[softmax_pkg::fifo_aw-1:0]] <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mx_cast.sv
`timescale 1ns/10ps
`default_nettype none

module mx_cast (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire softmax_pkg::mx_quo_t   in_data,
  input  wire                         in_valid,
  output logic                        in_ready,
  output softmax_pkg::mx_elem_t       out_data,
  output logic                        out_valid,
  input  wire                         out_ready
);

  logic [3:0]                     lz;
  logic [softmax_pkg::quo_w-1:0]  q_norm;
  logic [softmax_pkg::man_w-1:0]  m_top;
  logic [softmax_pkg::man_w-1:0]  m_rnd;
  logic                           rnd_bit;
  logic                           bump;
  int                             e_adj;
  softmax_pkg::mx_elem_t          cast_res;

  function automatic logic [3:0] lead_zeros(input logic [softmax_pkg::quo_w-1:0] v);
    lead_zeros = 4'(softmax_pkg::quo_w);
    for (int i = 0; i < softmax_pkg::quo_w; i++) begin
      if (v[i]) begin
        lead_zeros = 4'(softmax_pkg::quo_w - 1 - i);
      end
    end
  endfunction

  always_comb begin
    // Leading one lands just below the sign bit of the output mantissa
    lz = lead_zeros(in_data.man);
    q_norm = in_data.man << lz;
    m_top = {1'b0, q_norm[softmax_pkg::quo_w-1 -: softmax_pkg::man_w-1]};
    rnd_bit = q_norm[softmax_pkg::quo_w-softmax_pkg::man_w];
    m_rnd = m_top + {{(softmax_pkg::man_w - 1){1'b0}}, rnd_bit};
    // Rounding carry into the sign position renormalizes by one
    bump = m_rnd[softmax_pkg::man_w-1];
    e_adj = int'(in_data.exp) + (softmax_pkg::quo_w - 1 - softmax_pkg::div_guard) -
            int'(lz) + int'(bump);

    if (in_data.man == '0 || e_adj < -(2 ** (softmax_pkg::exp_w - 1))) begin
      cast_res.man = '0;
      cast_res.exp = {1'b1, {(softmax_pkg::exp_w - 1){1'b0}}};
    end else if (e_adj > (2 ** (softmax_pkg::exp_w - 1)) - 1) begin
      cast_res.man = {1'b0, {(softmax_pkg::man_w - 1){1'b1}}};
      cast_res.exp = {1'b0, {(softmax_pkg::exp_w - 1){1'b1}}};
    end else begin
      cast_res.man = bump ? {2'b01, {(softmax_pkg::man_w - 2){1'b0}}} : m_rnd;
      cast_res.exp = e_adj[softmax_pkg::exp_w-1:0];
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= cast_res;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mx_div.sv
`timescale 1ns/10ps
`default_nettype none

module mx_div (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire softmax_pkg::mx_elem_t  dvd_data,
  input  wire                         dvd_valid,
  output logic                        dvd_ready,
  input  wire softmax_pkg::mx_sum_t   dvs_data,
  input  wire                         dvs_valid,
  output logic                        dvs_ready,
  output softmax_pkg::mx_quo_t        quo_data,
  output logic                        quo_valid,
  input  wire                         quo_ready
);

  logic [softmax_pkg::quo_w-1:0]      num;
  logic [softmax_pkg::quo_w-1:0]      den;
  logic signed [softmax_pkg::exp_w:0] e_dvd;
  logic signed [softmax_pkg::exp_w:0] e_dvs;
  logic                               out_free;
  logic                               take;
  softmax_pkg::mx_quo_t               quo_nxt;

  // Both operands are consumed in the same transfer
  assign out_free = !quo_valid || quo_ready;
  assign dvd_ready = dvs_valid && out_free;
  assign dvs_ready = dvd_valid && out_free;
  assign take = dvd_valid && dvs_valid && out_free;

  always_comb begin
    num = {dvd_data.man, {(softmax_pkg::sum_guard + softmax_pkg::div_guard){1'b0}}};
    den = {{(softmax_pkg::quo_w - softmax_pkg::acc_w){1'b0}}, dvs_data.man};
    e_dvd = dvd_data.exp;
    e_dvs = dvs_data.exp;
    quo_nxt.exp = e_dvd - e_dvs;

    // Quotient keeps div_guard fraction bits, rounded to nearest
    if (den == '0) begin
      quo_nxt.man = '1;
    end else begin
      quo_nxt.man = (num + (den >> 1)) / den;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      quo_valid <= 1'b0;
    end else if (out_free) begin
      quo_valid <= dvd_valid && dvs_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      quo_data <= quo_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mx_exp.sv
`timescale 1ns/10ps
`default_nettype none

module mx_exp (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire softmax_pkg::mx_elem_t  in_data,
  input  wire                         in_valid,
  output logic                        in_ready,
  output softmax_pkg::mx_elem_t       out_data,
  output logic                        out_valid,
  input  wire                         out_ready
);

  logic signed [6:0]     man_x3;
  logic signed [8:0]     exp_x;
  logic signed [17:0]    y_q;
  logic signed [15:0]    y_int;
  softmax_pkg::mx_elem_t exp_res;

  // 2^f with f in quarters, as a mantissa with 2 fraction bits
  function automatic logic [softmax_pkg::man_w-1:0] pow2_frac(input logic [1:0] f);
    case (f)
      2'd0:    pow2_frac = 4'd4;
      2'd1:    pow2_frac = 4'd5;  // 1.19 rounds to 1.25
      2'd2:    pow2_frac = 4'd6;
      default: pow2_frac = 4'd7;
    endcase
  endfunction

  always_comb begin
    // x*1.5 as x + x/2, i.e. 3*man with one more fraction bit
    man_x3 = 7'(in_data.man) + (7'(in_data.man) <<< 1);
    exp_x = 9'(in_data.exp);

    // y in quarter units, shift clamped where the result saturates anyway
    if (exp_x > 9'sd11) begin
      y_q = 18'(man_x3) <<< 10;
    end else if (exp_x > 9'sd0) begin
      y_q = 18'(man_x3) <<< (exp_x - 9'sd1);
    end else if (exp_x > -9'sd8) begin
      y_q = 18'(man_x3) >>> (9'sd1 - exp_x);
    end else begin
      y_q = 18'(man_x3) >>> 8;
    end
    y_int = y_q[17:2];

    // Integer part goes to the exponent, fraction through the table
    if (int'(y_int) > (2 ** (softmax_pkg::exp_w - 1)) - 1) begin
      exp_res.man = {1'b0, {(softmax_pkg::man_w - 1){1'b1}}};
      exp_res.exp = {1'b0, {(softmax_pkg::exp_w - 1){1'b1}}};
    end else if (int'(y_int) < -(2 ** (softmax_pkg::exp_w - 1))) begin
      exp_res.man = {2'b01, {(softmax_pkg::man_w - 2){1'b0}}};
      exp_res.exp = {1'b1, {(softmax_pkg::exp_w - 1){1'b0}}};
    end else begin
      exp_res.man = pow2_frac(y_q[1:0]);
      exp_res.exp = y_int[softmax_pkg::exp_w-1:0];
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= exp_res;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mxint_softmax.sv
`timescale 1ns/10ps
`default_nettype none

module mxint_softmax (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire softmax_pkg::mx_elem_t  data_in,
  input  wire                         data_in_valid,
  output logic                        data_in_ready,
  output softmax_pkg::mx_elem_t       data_out,
  output logic                        data_out_valid,
  input  wire                         data_out_ready
);

  // Exponentials and their two copies
  softmax_pkg::mx_elem_t exp_data;
  logic                  exp_valid;
  logic                  exp_ready;
  softmax_pkg::mx_elem_t str_data;
  logic                  str_valid;
  logic                  str_ready;
  softmax_pkg::mx_elem_t fifo_data;
  logic                  fifo_valid;
  logic                  fifo_ready;

  // Vector sum, then its replays
  softmax_pkg::mx_sum_t  sum_data;
  logic                  sum_valid;
  logic                  sum_ready;
  softmax_pkg::mx_sum_t  rep_data;
  logic                  rep_valid;
  logic                  rep_ready;

  softmax_pkg::mx_quo_t  quo_data;
  logic                  quo_valid;
  logic                  quo_ready;

  mx_exp u_exp (
    .clk, .arst_n,
    .in_data(data_in), .in_valid(data_in_valid), .in_ready(data_in_ready),
    .out_data(exp_data), .out_valid(exp_valid), .out_ready(exp_ready)
  );

  exp_split_fifo u_split (
    .clk, .arst_n,
    .in_data(exp_data), .in_valid(exp_valid), .in_ready(exp_ready),
    .str_data, .str_valid, .str_ready,
    .fifo_data, .fifo_valid, .fifo_ready
  );

  exp_accumulator u_acc (
    .clk, .arst_n,
    .in_data(str_data), .in_valid(str_valid), .in_ready(str_ready),
    .sum_data, .sum_valid, .sum_ready
  );

  sum_repeat u_rep (
    .clk, .arst_n,
    .in_data(sum_data), .in_valid(sum_valid), .in_ready(sum_ready),
    .out_data(rep_data), .out_valid(rep_valid), .out_ready(rep_ready)
  );

  mx_div u_div (
    .clk, .arst_n,
    .dvd_data(fifo_data), .dvd_valid(fifo_valid), .dvd_ready(fifo_ready),
    .dvs_data(rep_data), .dvs_valid(rep_valid), .dvs_ready(rep_ready),
    .quo_data, .quo_valid, .quo_ready
  );

  mx_cast u_cast (
    .clk, .arst_n,
    .in_data(quo_data), .in_valid(quo_valid), .in_ready(quo_ready),
    .out_data(data_out), .out_valid(data_out_valid), .out_ready(data_out_ready)
  );

endmodule

`default_nettype wire

//--- verilog/softmax_pkg.sv
`default_nettype none

package softmax_pkg;

  // Vector shape
  localparam int vec_dim = 8;
  localparam int cnt_w = $clog2(vec_dim);

  // MXINT element format, mantissa carries 2 fraction bits
  localparam int man_w = 4;
  localparam int exp_w = 8;

  // Extra fraction bits for the sum and for the quotient
  localparam int sum_guard = 4;
  localparam int div_guard = 4;

  localparam int acc_w = cnt_w + man_w + sum_guard;
  localparam int quo_w = man_w + sum_guard + div_guard;

  // Exponential FIFO holds two vectors
  localparam int fifo_depth = 2 * vec_dim;
  localparam int fifo_aw = $clog2(fifo_depth);

  typedef struct packed {
    logic signed [man_w-1:0] man;
    logic signed [exp_w-1:0] exp;
  } mx_elem_t;

  typedef struct packed {
    logic        [acc_w-1:0] man;
    logic signed [exp_w-1:0] exp;
  } mx_sum_t;

  typedef struct packed {
    logic        [quo_w-1:0] man;
    logic signed [exp_w:0]   exp;
  } mx_quo_t;

endpackage

`default_nettype wire

//--- verilog/sum_repeat.sv
`timescale 1ns/10ps
`default_nettype none

module sum_repeat (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire softmax_pkg::mx_sum_t  in_data,
  input  wire                        in_valid,
  output logic                       in_ready,
  output softmax_pkg::mx_sum_t       out_data,
  output logic                       out_valid,
  input  wire                        out_ready
);

  softmax_pkg::mx_sum_t           hold_q;
  logic                           full;
  logic [softmax_pkg::cnt_w-1:0]  rep_cnt;

  assign in_ready = !full;
  assign out_valid = full;
  assign out_data = hold_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
      rep_cnt <= '0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
      rep_cnt <= '0;
    end else if (out_valid && out_ready) begin
      // Entry freed after the last replay of the vector
      if (rep_cnt == softmax_pkg::cnt_w'(softmax_pkg::vec_dim - 1)) begin
        full <= 1'b0;
        rep_cnt <= '0;
      end else begin
        rep_cnt <= rep_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      hold_q <= in_data;
    end
  end

endmodule

`default_nettype wire
